//--- src/i2c_init_params.svh
/*
 * widths, init word command codes and table size for the i2c init sequencer
 * include wherever these constants are needed
 */
`ifndef I2C_INIT_PARAMS_SVH
`define I2C_INIT_PARAMS_SVH

// bus field widths
`define I2C_ADDR_W 7
`define I2C_DATA_W 8

// one table entry
`define INIT_WORD_W 9

// init table size and index width
`define INIT_ROM_LEN 24
`define INIT_ROM_AW 5

// control words, top two bits zero
`define INIT_OP_END        9'h000
`define INIT_OP_EXIT       9'h001
`define INIT_OP_WRITE_CUR  9'h003
`define INIT_OP_ADDR_BLOCK 9'h008
`define INIT_OP_DATA_BLOCK 9'h009
`define INIT_OP_SEND_STOP  9'h041

`endif

//--- src/i2c_init_pkg.sv
/*
 * shared types for the i2c init sequencer
 * init word views, master command, issue requests and fsm states
 */
`include "i2c_init_params.svh"

package i2c_init_pkg;

    // data view of an init word
    typedef struct packed {
        logic                   is_data;
        logic [`I2C_DATA_W-1:0] data_byte;
    } init_data_t;

    // command view of an init word
    // opcode 01 carries an address, 00 a control code
    typedef struct packed {
        logic [1:0]             opcode;
        logic [`I2C_ADDR_W-1:0] field;
    } init_cmd_t;

    // one table entry, decoded both ways
    typedef union packed {
        init_data_t data;
        init_cmd_t  cmd;
    } init_word_u;

    // i2c master command word
    typedef struct packed {
        logic [`I2C_ADDR_W-1:0] address;
        logic                   start;
        logic                   write;
        logic                   stop;
    } i2c_cmd_t;

    // what the sequencer asks the issuer to do
    typedef enum logic [1:0] {
        ISSUE_NONE,
        ISSUE_ADDR,
        ISSUE_WRITE,
        ISSUE_STOP
    } issue_op_e;

    typedef struct packed {
        issue_op_e              op;
        logic [`I2C_ADDR_W-1:0] address;
        logic [`I2C_DATA_W-1:0] data_byte;
    } issue_req_t;

    // table walking states
    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_RUN,
        SEQ_FIND_ADDR_BLOCK,
        SEQ_NEXT_ADDR,
        SEQ_DATA_BLOCK
    } seq_state_e;

endpackage

//--- src/init_rom.sv
/*
 * fixed i2c init table with a registered read
 * word for rom_index appears one cycle later
 */
`timescale 1ns/1ps
`include "i2c_init_params.svh"

module init_rom (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [`INIT_ROM_AW-1:0]      rom_index,
    output i2c_init_pkg::init_word_u     init_word
);

    // table contents, unused indices read as end of table
    function automatic logic [`INIT_WORD_W-1:0] rom_lookup(
        input logic [`INIT_ROM_AW-1:0] idx
    );
        logic [`INIT_WORD_W-1:0] w;
        case (idx)
            // single device, 0x50 reg 0x0004 <= 0x11223344
            5'd0:  w = {2'b01, 7'h50};
            5'd1:  w = {1'b1, 8'h00};
            5'd2:  w = {1'b1, 8'h04};
            5'd3:  w = {1'b1, 8'h11};
            5'd4:  w = {1'b1, 8'h22};
            5'd5:  w = {1'b1, 8'h33};
            5'd6:  w = {1'b1, 8'h44};
            5'd7:  w = `INIT_OP_SEND_STOP;
            // not a defined code, gets skipped
            5'd8:  w = 9'h005;
            // same write replayed over four devices
            5'd9:  w = `INIT_OP_DATA_BLOCK;
            5'd10: w = `INIT_OP_WRITE_CUR;
            5'd11: w = {1'b1, 8'h00};
            5'd12: w = {1'b1, 8'h04};
            5'd13: w = {1'b1, 8'h11};
            5'd14: w = {1'b1, 8'h22};
            5'd15: w = {1'b1, 8'h33};
            5'd16: w = {1'b1, 8'h44};
            5'd17: w = `INIT_OP_ADDR_BLOCK;
            5'd18: w = {2'b01, 7'h50};
            5'd19: w = {2'b01, 7'h51};
            5'd20: w = {2'b01, 7'h52};
            5'd21: w = {2'b01, 7'h53};
            5'd22: w = `INIT_OP_EXIT;
            5'd23: w = `INIT_OP_END;
            default: w = `INIT_OP_END;
        endcase
        return w;
    endfunction

    // registered read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_word <= '0;
        end else begin
            init_word <= rom_lookup(rom_index);
        end
    end

endmodule

//--- src/init_sequencer.sv
/*
 * walks the init table and turns words into issue requests
 * handles single device writes and data block replay per stored address
 */
`timescale 1ns/1ps
`include "i2c_init_params.svh"

module init_sequencer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  i2c_init_pkg::init_word_u     init_word,
    input  logic                         pending,
    output logic [`INIT_ROM_AW-1:0]      rom_index,
    output i2c_init_pkg::issue_req_t     req,
    output logic                         running
);

    i2c_init_pkg::seq_state_e state_q, state_d;

    // table pointers
    logic [`INIT_ROM_AW-1:0] index_q, index_d;
    logic [`INIT_ROM_AW-1:0] data_ptr_q, data_ptr_d;
    logic [`INIT_ROM_AW-1:0] addr_ptr_q, addr_ptr_d;
    logic [`INIT_ROM_AW-1:0] index_inc;

    // device address for write-to-current
    logic [`I2C_ADDR_W-1:0] cur_addr_q, cur_addr_d;

    // start must drop before another run
    logic start_seen_q, start_seen_d;

    // word decode, data view
    logic w_data;
    // word decode, command view
    logic w_addr;
    logic w_end;
    logic w_exit;
    logic w_write_cur;
    logic w_addr_block;
    logic w_data_block;
    logic w_send_stop;

    assign w_data       = init_word.data.is_data;
    // opcode 01 means the field is a device address
    assign w_addr       = (init_word.cmd.opcode == 2'b01);
    assign w_end        = (init_word.cmd == `INIT_OP_END);
    assign w_exit       = (init_word.cmd == `INIT_OP_EXIT);
    assign w_write_cur  = (init_word.cmd == `INIT_OP_WRITE_CUR);
    assign w_addr_block = (init_word.cmd == `INIT_OP_ADDR_BLOCK);
    assign w_data_block = (init_word.cmd == `INIT_OP_DATA_BLOCK);
    assign w_send_stop  = (init_word.cmd == `INIT_OP_SEND_STOP);

    assign index_inc = index_q + 1'b1;

    // rom reads the next index so its word lines up with index_q
    assign rom_index = index_d;
    assign running   = (state_q != i2c_init_pkg::SEQ_IDLE);

    always_comb begin
        state_d      = state_q;
        index_d      = index_q;
        data_ptr_d   = data_ptr_q;
        addr_ptr_d   = addr_ptr_q;
        cur_addr_d   = cur_addr_q;
        start_seen_d = start_seen_q;

        // payload follows the word, op picks what is used
        req.op        = i2c_init_pkg::ISSUE_NONE;
        req.address   = init_word.cmd.field;
        req.data_byte = init_word.data.data_byte;

        // output stage busy, hold everything
        if (!pending) begin
            if (state_q == i2c_init_pkg::SEQ_IDLE) begin
                // new run on start, only if start was low since the last one
                if (start && !start_seen_q) begin
                    index_d      = '0;
                    start_seen_d = 1'b1;
                    state_d      = i2c_init_pkg::SEQ_RUN;
                end
            end else if (w_end) begin
                // end of table, stop the bus and go idle
                req.op  = i2c_init_pkg::ISSUE_STOP;
                state_d = i2c_init_pkg::SEQ_IDLE;
            end else if (w_exit) begin
                // leave multi device mode
                index_d = index_inc;
                state_d = i2c_init_pkg::SEQ_RUN;
            end else if (w_data_block) begin
                // remember block start, then look for the addresses
                data_ptr_d = index_inc;
                index_d    = index_inc;
                state_d    = i2c_init_pkg::SEQ_FIND_ADDR_BLOCK;
            end else begin
                // anything not matched below is skipped
                index_d = index_inc;
                case (state_q)
                    i2c_init_pkg::SEQ_RUN: begin
                        if (w_data) begin
                            req.op = i2c_init_pkg::ISSUE_WRITE;
                        end else if (w_addr) begin
                            req.op = i2c_init_pkg::ISSUE_ADDR;
                        end else if (w_send_stop) begin
                            req.op = i2c_init_pkg::ISSUE_STOP;
                        end
                    end
                    i2c_init_pkg::SEQ_FIND_ADDR_BLOCK: begin
                        // skip data block body until address list
                        if (w_addr_block) begin
                            addr_ptr_d = index_inc;
                            state_d    = i2c_init_pkg::SEQ_NEXT_ADDR;
                        end
                    end
                    i2c_init_pkg::SEQ_NEXT_ADDR: begin
                        // take next address, jump back to data block
                        if (w_addr) begin
                            cur_addr_d = init_word.cmd.field;
                            addr_ptr_d = index_inc;
                            index_d    = data_ptr_q;
                            state_d    = i2c_init_pkg::SEQ_DATA_BLOCK;
                        end
                    end
                    i2c_init_pkg::SEQ_DATA_BLOCK: begin
                        if (w_data) begin
                            req.op = i2c_init_pkg::ISSUE_WRITE;
                        end else if (w_addr) begin
                            req.op = i2c_init_pkg::ISSUE_ADDR;
                        end else if (w_write_cur) begin
                            // substitute the stored device address
                            req.op      = i2c_init_pkg::ISSUE_ADDR;
                            req.address = cur_addr_q;
                        end else if (w_send_stop) begin
                            req.op = i2c_init_pkg::ISSUE_STOP;
                        end else if (w_addr_block) begin
                            // block done, back to the address list
                            index_d = addr_ptr_q;
                            state_d = i2c_init_pkg::SEQ_NEXT_ADDR;
                        end
                    end
                    default: begin
                        state_d = i2c_init_pkg::SEQ_IDLE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q      <= i2c_init_pkg::SEQ_IDLE;
            index_q      <= '0;
            data_ptr_q   <= '0;
            addr_ptr_q   <= '0;
            cur_addr_q   <= '0;
            start_seen_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            index_q      <= index_d;
            data_ptr_q   <= data_ptr_d;
            addr_ptr_q   <= addr_ptr_d;
            cur_addr_q   <= cur_addr_d;
            // flag clears as soon as start goes low
            start_seen_q <= start_seen_d & start;
        end
    end

    // table walk never reads past the last entry
    a_index_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        rom_index < `INIT_ROM_LEN
    );

endmodule

//--- src/i2c_cmd_issuer.sv
/*
 * output register stage for i2c master command and data channels
 * applies one issue request per cycle, holds valid until accepted
 */
`timescale 1ns/1ps
`include "i2c_init_params.svh"

module i2c_cmd_issuer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  i2c_init_pkg::issue_req_t     req,
    output i2c_init_pkg::i2c_cmd_t       cmd,
    output logic                         cmd_valid,
    input  logic                         cmd_ready,
    output logic [`I2C_DATA_W-1:0]       data_out,
    output logic                         data_out_valid,
    input  logic                         data_out_ready,
    output logic                         pending
);

    logic [`I2C_ADDR_W-1:0] addr_q;
    logic start_q;
    logic write_q;
    logic stop_q;

    // transfers on each channel
    logic cmd_xfer;
    logic data_xfer;

    assign cmd_xfer  = cmd_valid & cmd_ready;
    assign data_xfer = data_out_valid & data_out_ready;

    assign cmd = '{address: addr_q, start: start_q, write: write_q, stop: stop_q};

    // sequencer waits on this
    assign pending = cmd_valid | data_out_valid;

    // flags and valids
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start_q        <= 1'b0;
            write_q        <= 1'b0;
            stop_q         <= 1'b0;
            cmd_valid      <= 1'b0;
            data_out_valid <= 1'b0;
        end else begin
            // accepted command, flags are spent
            if (cmd_xfer) begin
                start_q   <= 1'b0;
                write_q   <= 1'b0;
                stop_q    <= 1'b0;
                cmd_valid <= 1'b0;
            end
            if (data_xfer) begin
                data_out_valid <= 1'b0;
            end
            case (req.op)
                i2c_init_pkg::ISSUE_ADDR: begin
                    // start rides along with the next write
                    start_q <= 1'b1;
                end
                i2c_init_pkg::ISSUE_WRITE: begin
                    write_q        <= 1'b1;
                    stop_q         <= 1'b0;
                    cmd_valid      <= 1'b1;
                    data_out_valid <= 1'b1;
                end
                i2c_init_pkg::ISSUE_STOP: begin
                    start_q   <= 1'b0;
                    write_q   <= 1'b0;
                    stop_q    <= 1'b1;
                    cmd_valid <= 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    // address and byte payload
    always_ff @(posedge clk) begin
        if (req.op == i2c_init_pkg::ISSUE_ADDR) begin
            addr_q <= req.address;
        end
        if (req.op == i2c_init_pkg::ISSUE_WRITE) begin
            data_out <= req.data_byte;
        end
    end

    // held command stays put under back-pressure
    a_cmd_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd)
    );

    a_data_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        data_out_valid && !data_out_ready |=> data_out_valid && $stable(data_out)
    );

    // sequencer must stall while outputs are in flight
    a_no_req_when_pending: assert property (
        @(posedge clk) disable iff (!rst_n)
        pending |-> req.op == i2c_init_pkg::ISSUE_NONE
    );

endmodule

//--- src/i2c_init.sv
/*
 * i2c bus init sequencer, top level
 * start runs the fixed table out on the cmd and data channels
 */
`timescale 1ns/1ps
`include "i2c_init_params.svh"

module i2c_init (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    output i2c_init_pkg::i2c_cmd_t       cmd,
    output logic                         cmd_valid,
    input  logic                         cmd_ready,
    output logic [`I2C_DATA_W-1:0]       data_out,
    output logic                         data_out_valid,
    input  logic                         data_out_ready,
    output logic                         busy
);

    logic [`INIT_ROM_AW-1:0]  rom_index;
    i2c_init_pkg::init_word_u init_word;
    i2c_init_pkg::issue_req_t req;
    logic                     pending;
    logic                     running;

    init_rom init_rom_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rom_index (rom_index),
        .init_word (init_word)
    );

    init_sequencer init_sequencer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .init_word (init_word),
        .pending   (pending),
        .rom_index (rom_index),
        .req       (req),
        .running   (running)
    );

    i2c_cmd_issuer i2c_cmd_issuer_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .req            (req),
        .cmd            (cmd),
        .cmd_valid      (cmd_valid),
        .cmd_ready      (cmd_ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready),
        .pending        (pending)
    );

    // busy lags the fsm by one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else begin
            busy <= running;
        end
    end

endmodule

//--- tests/i2c_init_expected.svh
/*
 * expected cmd and data transfers for one full run of the init table
 * included inside the testbench module
 */
`ifndef I2C_INIT_EXPECTED_SVH
`define I2C_INIT_EXPECTED_SVH

localparam int EXP_CMD_N  = 32;
localparam int EXP_DATA_N = 30;

// columns are address then start, write, stop
// stop keeps the address of the last addressed device
i2c_init_pkg::i2c_cmd_t exp_cmd [0:EXP_CMD_N-1] = '{
    // single device 0x50
    {7'h50, 3'b110}, {7'h50, 3'b010}, {7'h50, 3'b010},
    {7'h50, 3'b010}, {7'h50, 3'b010}, {7'h50, 3'b010},
    {7'h50, 3'b001},
    // data block replayed for 0x50
    {7'h50, 3'b110}, {7'h50, 3'b010}, {7'h50, 3'b010},
    {7'h50, 3'b010}, {7'h50, 3'b010}, {7'h50, 3'b010},
    // replay for 0x51
    {7'h51, 3'b110}, {7'h51, 3'b010}, {7'h51, 3'b010},
    {7'h51, 3'b010}, {7'h51, 3'b010}, {7'h51, 3'b010},
    // replay for 0x52
    {7'h52, 3'b110}, {7'h52, 3'b010}, {7'h52, 3'b010},
    {7'h52, 3'b010}, {7'h52, 3'b010}, {7'h52, 3'b010},
    // replay for 0x53, then end of table stop
    {7'h53, 3'b110}, {7'h53, 3'b010}, {7'h53, 3'b010},
    {7'h53, 3'b010}, {7'h53, 3'b010}, {7'h53, 3'b010},
    {7'h53, 3'b001}
};

// register 0x0004 then 0x11223344, once per device write
logic [`I2C_DATA_W-1:0] exp_data [0:EXP_DATA_N-1] = '{
    8'h00, 8'h04, 8'h11, 8'h22, 8'h33, 8'h44,
    8'h00, 8'h04, 8'h11, 8'h22, 8'h33, 8'h44,
    8'h00, 8'h04, 8'h11, 8'h22, 8'h33, 8'h44,
    8'h00, 8'h04, 8'h11, 8'h22, 8'h33, 8'h44,
    8'h00, 8'h04, 8'h11, 8'h22, 8'h33, 8'h44
};

`endif

//--- tests/tb_i2c_init.sv
/*
 * testbench for the i2c init sequencer
 * runs the table several times with fixed or random ready and checks every transfer
 */
`timescale 1ns/1ps
`include "i2c_init_params.svh"

module tb_i2c_init;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_STEPS  = 5;
    localparam int IDLE_WAIT  = 20;

    `include "i2c_init_expected.svh"

    // one run with start held afterwards and random ready
    typedef struct packed {
        logic hold_start;
        logic rand_ready;
    } run_step_t;

    // bit order is hold_start, rand_ready
    run_step_t run_steps [0:NUM_STEPS-1] = '{2'b00, 2'b10, 2'b01, 2'b11, 2'b00};

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   start;
    i2c_init_pkg::i2c_cmd_t cmd;
    logic                   cmd_valid;
    logic                   cmd_ready;
    logic [`I2C_DATA_W-1:0] data_out;
    logic                   data_out_valid;
    logic                   data_out_ready;
    logic                   busy;

    logic                   rand_mode;
    logic [31:0]            rng_state = 32'h729ac3af;

    // transfer counts over all runs
    int                     cmd_total = 0;
    int                     data_total = 0;

    // values seen held under back-pressure
    logic                   cmd_held = 1'b0;
    logic                   data_held = 1'b0;
    i2c_init_pkg::i2c_cmd_t held_cmd;
    logic [`I2C_DATA_W-1:0] held_data;

    i2c_init i2c_init_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .cmd            (cmd),
        .cmd_valid      (cmd_valid),
        .cmd_ready      (cmd_ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready),
        .busy           (busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // ready pattern from two generator bits per cycle
    always @(posedge clk) begin
        rng_state = xorshift32(rng_state);
        if (rand_mode) begin
            cmd_ready      <= rng_state[3];
            data_out_ready <= rng_state[17];
        end else begin
            cmd_ready      <= 1'b1;
            data_out_ready <= 1'b1;
        end
    end

    // transfer monitor
    always @(posedge clk) begin
        if (rst_n) begin
            // value stalled last cycle must be unchanged
            if (cmd_held) begin
                check_value("cmd_valid", cmd_valid, 1'b1);
                check_value("cmd", cmd, held_cmd);
            end
            if (data_held) begin
                check_value("data_out_valid", data_out_valid, 1'b1);
                check_value("data_out", data_out, held_data);
            end
            if (cmd_valid && cmd_ready) begin
                check_value("cmd", cmd, exp_cmd[cmd_total % EXP_CMD_N]);
                cmd_total <= cmd_total + 1;
            end
            if (data_out_valid && data_out_ready) begin
                check_value("data_out", data_out, exp_data[data_total % EXP_DATA_N]);
                // bytes only go out while the table is being walked
                check_value("busy", busy, 1'b1);
                data_total <= data_total + 1;
            end
            cmd_held  <= cmd_valid && !cmd_ready;
            held_cmd  <= cmd;
            data_held <= data_out_valid && !data_out_ready;
            held_data <= data_out;
        end
    end

    // one full run plus a quiet window afterwards
    task automatic run_step(input int step_idx, input run_step_t step);
        int cmd_target;
        int data_target;
        cmd_target  = (step_idx + 1) * EXP_CMD_N;
        data_target = (step_idx + 1) * EXP_DATA_N;
        // start low first so a new run is allowed
        start     <= 1'b0;
        rand_mode <= step.rand_ready;
        repeat (2) @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        if (!step.hold_start) begin
            start <= 1'b0;
        end
        while (cmd_total < cmd_target || data_total < data_target || busy) begin
            @(posedge clk);
        end
        // nothing more even with start still held high
        repeat (IDLE_WAIT) begin
            @(posedge clk);
            check_value("busy", busy, 1'b0);
            check_value("cmd_valid", cmd_valid, 1'b0);
            check_value("data_out_valid", data_out_valid, 1'b0);
        end
        check_value("cmd transfer count", cmd_total, cmd_target);
        check_value("data transfer count", data_total, data_target);
    endtask

    initial begin
        rst_n          = 1'b0;
        start          = 1'b0;
        cmd_ready      = 1'b0;
        data_out_ready = 1'b0;
        rand_mode      = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        // quiet after reset
        check_value("cmd_valid", cmd_valid, 1'b0);
        check_value("data_out_valid", data_out_valid, 1'b0);
        check_value("busy", busy, 1'b0);
        for (int i = 0; i < NUM_STEPS; i++) begin
            run_step(i, run_steps[i]);
        end
        $display("STATUS: PASS");
        $finish;
    end

    // generous bound per transaction
    initial begin
        #(NUM_STEPS * EXP_CMD_N * 40 * CLK_PERIOD);
        $display("watchdog expired, the runs did not complete in time");
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    end

endmodule

//--- tb.f
+incdir+src
+incdir+tests
src/i2c_init_pkg.sv
src/init_rom.sv
src/init_sequencer.sv
src/i2c_cmd_issuer.sv
src/i2c_init.sv
tests/tb_i2c_init.sv
